/* logic/cube_pkg.sv */
////////////////////////////////////////////////////////////
// Shared cube dimensions, dwell length, vector types and
// the plane and mode enums
////////////////////////////////////////////////////////////

`default_nettype none

package cube_pkg;

	////////////////////////////////////////////////////////////
	// Cube geometry

	// Horizontal layers, bottom is index 0
	localparam int N_LAYERS = 3;

	// Vertical columns, index is row*3 + position
	localparam int N_COLUMNS = 9;

	// Border walk frames per layer
	localparam int STEPS_PER_PLANE = 8;

	////////////////////////////////////////////////////////////
	// Frame timing

	// Clocks each frame stays on the cube
	localparam int DWELL_TICKS = 100;

	// Wide enough for DWELL_TICKS-1
	localparam int DWELL_W = 7;

	////////////////////////////////////////////////////////////
	// Vector types

	// Layer power, a low bit powers that layer
	typedef logic [N_LAYERS-1:0] layer_t;

	// Column drive, a high bit lights that column
	typedef logic [N_COLUMNS-1:0] column_t;

	// Position within the border walk
	typedef logic [2:0] step_t;

	// Layer currently being walked
	typedef enum logic [1:0] {
		PLANE_BOT = 2'd0,
		PLANE_MID = 2'd1,
		PLANE_TOP = 2'd2
	} plane_e;

	// Controller state
	typedef enum logic [1:0] {
		MODE_IDLE      = 2'd0,
		MODE_LAMP_TEST = 2'd1,
		MODE_RUN       = 2'd2
	} mode_e;

endpackage

`default_nettype wire

/* logic/cube_sequencer.sv */
////////////////////////////////////////////////////////////
// Mode FSM for idle, lamp test and run, with frame strobes
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cube_sequencer (
	input  logic            clk_1Hz,
	input  logic            reset_n,
	input  logic            go_n,
	input  logic            lamp_test_n,
	input  logic            reverse_n,
	input  logic            dwell_done,
	output cube_pkg::mode_e mode,
	output logic            start,
	output logic            timer_clear,
	output logic            step_fwd,
	output logic            step_back
);

	cube_pkg::mode_e mode_next;
	logic            frame_end;

	////////////////////////////////////////////////////////////
	// Next mode

	always_comb begin
		mode_next = mode;
		case (mode)
			cube_pkg::MODE_IDLE: begin
				// Go wins over lamp test
				if (!go_n) begin
					mode_next = cube_pkg::MODE_RUN;
				end else if (!lamp_test_n) begin
					mode_next = cube_pkg::MODE_LAMP_TEST;
				end
			end
			cube_pkg::MODE_LAMP_TEST: begin
				if (lamp_test_n) begin
					mode_next = cube_pkg::MODE_IDLE;
				end
			end
			cube_pkg::MODE_RUN: begin
				// Only reset leaves the run
				mode_next = cube_pkg::MODE_RUN;
			end
			default: begin
				mode_next = cube_pkg::MODE_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_1Hz or negedge reset_n) begin
		if (!reset_n) begin
			mode <= cube_pkg::MODE_IDLE;
		end else begin
			mode <= mode_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Strobes

	// Leaving idle for run on this edge
	assign start = (mode == cube_pkg::MODE_IDLE) && !go_n;

	// Last clock of the current frame
	assign frame_end = (mode == cube_pkg::MODE_RUN) && dwell_done;

	assign timer_clear = start || frame_end;

	// Direction is taken from the reverse key at the end of the dwell
	assign step_fwd  = frame_end && reverse_n;
	assign step_back = frame_end && !reverse_n;

	step_dir_exclusive: assert property (
		@(posedge clk_1Hz) disable iff (!reset_n)
		frame_end |-> $onehot({step_fwd, step_back})
	) else $error("step_fwd and step_back not exclusive at frame end");

endmodule

`default_nettype wire

/* logic/dwell_timer.sv */
////////////////////////////////////////////////////////////
// Frame dwell counter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dwell_timer (
	input  logic clk_1Hz,
	input  logic reset_n,
	input  logic timer_clear,
	output logic dwell_done
);

	logic [cube_pkg::DWELL_W-1:0] count;

	// Last clock of the frame
	assign dwell_done = (count == cube_pkg::DWELL_TICKS - 1);

	always_ff @(posedge clk_1Hz or negedge reset_n) begin
		if (!reset_n) begin
			count <= '0;
		end else if (timer_clear || dwell_done) begin
			// Wraps on its own while nobody clears it
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	count_in_range: assert property (
		@(posedge clk_1Hz) disable iff (!reset_n)
		count <= cube_pkg::DWELL_TICKS - 1
	) else $error("dwell count %0d out of range", count);

endmodule

`default_nettype wire

/* logic/frame_stepper.sv */
////////////////////////////////////////////////////////////
// Walk position with plane wrap and interleave phase
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module frame_stepper (
	input  logic             clk_1Hz,
	input  logic             reset_n,
	input  logic             start,
	input  logic             step_fwd,
	input  logic             step_back,
	output cube_pkg::plane_e plane,
	output cube_pkg::step_t  step,
	output logic             phase
);

	cube_pkg::plane_e plane_up;
	cube_pkg::plane_e plane_down;
	logic             last_step;

	// Neighbouring planes, top and bottom wrap
	always_comb begin
		case (plane)
			cube_pkg::PLANE_BOT: begin
				plane_up   = cube_pkg::PLANE_MID;
				plane_down = cube_pkg::PLANE_TOP;
			end
			cube_pkg::PLANE_MID: begin
				plane_up   = cube_pkg::PLANE_TOP;
				plane_down = cube_pkg::PLANE_BOT;
			end
			default: begin
				plane_up   = cube_pkg::PLANE_BOT;
				plane_down = cube_pkg::PLANE_MID;
			end
		endcase
	end

	assign last_step = (step == cube_pkg::STEPS_PER_PLANE - 1);

	always_ff @(posedge clk_1Hz or negedge reset_n) begin
		if (!reset_n) begin
			plane <= cube_pkg::PLANE_BOT;
			step  <= '0;
			phase <= 1'b0;
		end else if (start) begin
			plane <= cube_pkg::PLANE_BOT;
			step  <= '0;
			phase <= 1'b0;
		end else if (step_fwd) begin
			phase <= 1'b0;
			if (last_step) begin
				plane <= plane_up;
				step  <= '0;
			end else begin
				step <= step + 3'd1;
			end
		end else if (step_back) begin
			phase <= 1'b0;
			if (step == '0) begin
				plane <= plane_down;
				step  <= cube_pkg::step_t'(cube_pkg::STEPS_PER_PLANE - 1);
			end else begin
				step <= step - 3'd1;
			end
		end else begin
			// Interleave runs only on the final step
			phase <= last_step ? !phase : 1'b0;
		end
	end

	position_legal: assert property (
		@(posedge clk_1Hz) disable iff (!reset_n)
		step < cube_pkg::STEPS_PER_PLANE &&
		plane inside {cube_pkg::PLANE_BOT, cube_pkg::PLANE_MID, cube_pkg::PLANE_TOP}
	) else $error("illegal walk position plane=%0d step=%0d", plane, step);

endmodule

`default_nettype wire

/* logic/frame_pattern.sv */
////////////////////////////////////////////////////////////
// Frame lookup from plane, step and phase to layer and
// column levels
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module frame_pattern (
	input  cube_pkg::plane_e  plane,
	input  cube_pkg::step_t   step,
	input  logic              phase,
	output cube_pkg::layer_t  pattern_layer,
	output cube_pkg::column_t pattern_column
);

	cube_pkg::plane_e lit_plane;

	////////////////////////////////////////////////////////////
	// Layer select

	// Corner half of the interleave sits one layer up
	always_comb begin
		lit_plane = plane;
		if (phase) begin
			case (plane)
				cube_pkg::PLANE_BOT: lit_plane = cube_pkg::PLANE_MID;
				cube_pkg::PLANE_MID: lit_plane = cube_pkg::PLANE_TOP;
				default:             lit_plane = cube_pkg::PLANE_BOT;
			endcase
		end
	end

	// Active low, one layer powered
	always_comb begin
		case (lit_plane)
			cube_pkg::PLANE_MID: pattern_layer = 3'b101;
			cube_pkg::PLANE_TOP: pattern_layer = 3'b011;
			default:             pattern_layer = 3'b110;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Column select

	// Pair of columns walking the 3x3 border
	always_comb begin
		case (step)
			// Columns 0 and 1
			3'd0: pattern_column = 9'b000_000_011;
			// Columns 1 and 2
			3'd1: pattern_column = 9'b000_000_110;
			// Columns 2 and 5
			3'd2: pattern_column = 9'b000_100_100;
			// Columns 5 and 8
			3'd3: pattern_column = 9'b100_100_000;
			// Columns 7 and 8
			3'd4: pattern_column = 9'b110_000_000;
			// Columns 6 and 7
			3'd5: pattern_column = 9'b011_000_000;
			// Columns 3 and 6
			3'd6: pattern_column = 9'b001_001_000;
			default: begin
				// Step 7, column 3 then the corner column 0
				if (phase) begin
					pattern_column = 9'b000_000_001;
				end else begin
					pattern_column = 9'b000_001_000;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/cube_driver.sv */
////////////////////////////////////////////////////////////
// Registered output stage for layer power and columns
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module cube_driver (
	input  logic              clk_1Hz,
	input  logic              reset_n,
	input  cube_pkg::mode_e   mode,
	input  cube_pkg::layer_t  pattern_layer,
	input  cube_pkg::column_t pattern_column,
	output cube_pkg::layer_t  layer_pwr,
	output cube_pkg::column_t column
);

	always_ff @(posedge clk_1Hz or negedge reset_n) begin
		if (!reset_n) begin
			layer_pwr <= '0;
			column    <= '0;
		end else begin
			case (mode)
				cube_pkg::MODE_LAMP_TEST: begin
					// Every layer powered, every column lit
					layer_pwr <= '0;
					column    <= '1;
				end
				cube_pkg::MODE_RUN: begin
					layer_pwr <= pattern_layer;
					column    <= pattern_column;
				end
				default: begin
					// Dark, no column driven
					layer_pwr <= '0;
					column    <= '0;
				end
			endcase
		end
	end

	// Outputs lag mode by one clock
	one_layer_in_run: assert property (
		@(posedge clk_1Hz) disable iff (!reset_n)
		(mode == cube_pkg::MODE_RUN) |=> $countones(~layer_pwr) == 1
	) else $error("run frame with layer_pwr %b", layer_pwr);

endmodule

`default_nettype wire

/* logic/led_cube_top.sv */
////////////////////////////////////////////////////////////
// LED cube top, sequencer plus frame datapath
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module led_cube_top (
	input  logic              clk_1Hz,
	input  logic              reset_n,
	input  logic              go_n,
	input  logic              lamp_test_n,
	input  logic              reverse_n,
	output cube_pkg::layer_t  layer_pwr,
	output cube_pkg::column_t column
);

	// Control
	cube_pkg::mode_e   mode;
	logic              start;
	logic              timer_clear;
	logic              dwell_done;
	logic              step_fwd;
	logic              step_back;

	// Walk position and frame
	cube_pkg::plane_e  plane;
	cube_pkg::step_t   step;
	logic              phase;
	cube_pkg::layer_t  pattern_layer;
	cube_pkg::column_t pattern_column;

	cube_sequencer sequencer_i (
		.clk_1Hz     (clk_1Hz),
		.reset_n     (reset_n),
		.go_n        (go_n),
		.lamp_test_n (lamp_test_n),
		.reverse_n   (reverse_n),
		.dwell_done  (dwell_done),
		.mode        (mode),
		.start       (start),
		.timer_clear (timer_clear),
		.step_fwd    (step_fwd),
		.step_back   (step_back)
	);

	dwell_timer dwell_timer_i (
		.clk_1Hz     (clk_1Hz),
		.reset_n     (reset_n),
		.timer_clear (timer_clear),
		.dwell_done  (dwell_done)
	);

	frame_stepper frame_stepper_i (
		.clk_1Hz   (clk_1Hz),
		.reset_n   (reset_n),
		.start     (start),
		.step_fwd  (step_fwd),
		.step_back (step_back),
		.plane     (plane),
		.step      (step),
		.phase     (phase)
	);

	frame_pattern frame_pattern_i (
		.plane          (plane),
		.step           (step),
		.phase          (phase),
		.pattern_layer  (pattern_layer),
		.pattern_column (pattern_column)
	);

	cube_driver cube_driver_i (
		.clk_1Hz        (clk_1Hz),
		.reset_n        (reset_n),
		.mode           (mode),
		.pattern_layer  (pattern_layer),
		.pattern_column (pattern_column),
		.layer_pwr      (layer_pwr),
		.column         (column)
	);

endmodule

`default_nettype wire

/* verif/tb_led_cube.sv */
////////////////////////////////////////////////////////////
// LED cube testbench with key stimulus, reference walk
// model and output assertions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_led_cube;

	logic              clk_1Hz;
	logic              reset_n;
	logic              go_n;
	logic              lamp_test_n;
	logic              reverse_n;
	cube_pkg::layer_t  layer_pwr;
	cube_pkg::column_t column;

	int error_count;
	int check_count;
	bit timed_out;

	// Expected output class, set on the falling edge
	bit expect_dark;
	bit expect_run;

	led_cube_top led_cube_top_i (
		.clk_1Hz     (clk_1Hz),
		.reset_n     (reset_n),
		.go_n        (go_n),
		.lamp_test_n (lamp_test_n),
		.reverse_n   (reverse_n),
		.layer_pwr   (layer_pwr),
		.column      (column)
	);

	initial begin
		clk_1Hz = 1'b0;
		forever #10 clk_1Hz = ~clk_1Hz;
	end

	////////////////////////////////////////////////////////////
	// Reference frame table

	// Border walk, two columns per step, index is row*3 + position
	function automatic cube_pkg::column_t border_columns(input int step_idx, input bit corner);
		cube_pkg::column_t cols;
		cols = '0;
		case (step_idx)
			0: cols = (9'd1 << 0) | (9'd1 << 1);
			1: cols = (9'd1 << 1) | (9'd1 << 2);
			2: cols = (9'd1 << 2) | (9'd1 << 5);
			3: cols = (9'd1 << 5) | (9'd1 << 8);
			4: cols = (9'd1 << 7) | (9'd1 << 8);
			5: cols = (9'd1 << 6) | (9'd1 << 7);
			6: cols = (9'd1 << 3) | (9'd1 << 6);
			default: cols = corner ? (9'd1 << 0) : (9'd1 << 3);
		endcase
		return cols;
	endfunction

	// One layer powered, active low
	function automatic cube_pkg::layer_t powered_layer(input int plane_idx);
		cube_pkg::layer_t lay;
		lay = '1;
		lay[plane_idx] = 1'b0;
		return lay;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks

	dark_when_idle: assert property (
		@(posedge clk_1Hz) disable iff (!reset_n)
		expect_dark |-> (layer_pwr == '0 && column == '0)
	) else begin
		error_count++;
		$display("error idle_dark expected 000/000000000 actual %b/%b", layer_pwr, column);
	end

	single_layer_in_run: assert property (
		@(posedge clk_1Hz) disable iff (!reset_n)
		expect_run |-> $countones(~layer_pwr) == 1
	) else begin
		error_count++;
		$display("error single_layer expected one low bit actual %b", layer_pwr);
	end

	task automatic compare_outputs(input string name, input cube_pkg::layer_t exp_layer,
			input cube_pkg::column_t exp_col);
		check_count++;
		assert (layer_pwr === exp_layer) else begin
			error_count++;
			$display("error %s layer_pwr expected %b actual %b", name, exp_layer, layer_pwr);
		end
		assert (column === exp_col) else begin
			error_count++;
			$display("error %s column expected %b actual %b", name, exp_col, column);
		end
	endtask

	// Leaves the caller on the falling edge where column first matches
	task automatic wait_for_columns(input string what, input cube_pkg::column_t target,
			input int limit);
		int n;
		n = 0;
		while (column !== target && n < limit) begin
			@(negedge clk_1Hz);
			n++;
		end
		if (column !== target) begin
			timed_out = 1'b1;
			$display("timeout after %0d clocks waiting for %s", limit, what);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk_1Hz);
		reset_n = 1'b0;
		repeat (4) @(negedge clk_1Hz);
		reset_n = 1'b1;
	endtask

	// Starts on the first clock of the bottom step 0 frame
	task automatic follow_walk(input string name, input bit backwards, input int frames);
		int plane_idx;
		int step_idx;
		int f;
		int tick;
		bit corner;
		cube_pkg::layer_t exp_layer;
		cube_pkg::column_t exp_col;
		plane_idx = 0;
		step_idx = 0;
		for (f = 0; f < frames; f++) begin
			for (tick = 0; tick < cube_pkg::DWELL_TICKS; tick++) begin
				// Interleave starts on the center half
				corner = (step_idx == 7) && (tick % 2 == 1);
				exp_col = border_columns(step_idx, corner);
				exp_layer = corner ? powered_layer((plane_idx + 1) % 3) : powered_layer(plane_idx);
				compare_outputs(name, exp_layer, exp_col);
				@(negedge clk_1Hz);
			end
			if (!backwards) begin
				step_idx++;
				if (step_idx == 8) begin
					step_idx = 0;
					plane_idx = (plane_idx + 1) % 3;
				end
			end else if (step_idx == 0) begin
				step_idx = 7;
				plane_idx = (plane_idx + 2) % 3;
			end else begin
				step_idx--;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Tests

	task automatic check_idle_dark();
		expect_dark = 1'b1;
		repeat (10) begin
			@(negedge clk_1Hz);
			compare_outputs("idle_dark", '0, '0);
		end
	endtask

	task automatic check_lamp_test();
		if (timed_out) return;
		expect_dark = 1'b0;
		lamp_test_n = 1'b0;
		wait_for_columns("lamp test on", '1, 10);
		if (timed_out) return;
		repeat (5) begin
			compare_outputs("lamp_test", '0, '1);
			@(negedge clk_1Hz);
		end
		lamp_test_n = 1'b1;
		wait_for_columns("lamp test off", '0, 10);
		if (timed_out) return;
		compare_outputs("lamp_release", '0, '0);
		expect_dark = 1'b1;
		repeat (5) @(negedge clk_1Hz);
	endtask

	task automatic start_run(input bit backwards);
		expect_dark = 1'b0;
		reverse_n = !backwards;
		go_n = 1'b0;
		@(negedge clk_1Hz);
		go_n = 1'b1;
		wait_for_columns("first run frame", border_columns(0, 1'b0), 10);
		expect_run = !timed_out;
	endtask

	task automatic check_forward_walk();
		if (timed_out) return;
		start_run(1'b0);
		if (timed_out) return;
		// Three planes and the wrap back to bottom
		follow_walk("forward_walk", 1'b0, 3 * cube_pkg::STEPS_PER_PLANE + 1);
	endtask

	task automatic check_reset_mid_run();
		if (timed_out) return;
		expect_run = 1'b0;
		reset_n = 1'b0;
		// Asynchronous, so no edge is needed
		#1;
		compare_outputs("reset_mid_run", '0, '0);
		repeat (4) @(negedge clk_1Hz);
		reset_n = 1'b1;
		expect_dark = 1'b1;
		repeat (5) begin
			@(negedge clk_1Hz);
			compare_outputs("idle_after_reset", '0, '0);
		end
	endtask

	task automatic check_reverse_walk();
		if (timed_out) return;
		start_run(1'b1);
		if (timed_out) return;
		// Bottom 0, all of top, then into middle
		follow_walk("reverse_walk", 1'b1, 11);
		reverse_n = 1'b1;
	endtask

	initial begin
		reset_n = 1'b0;
		go_n = 1'b1;
		lamp_test_n = 1'b1;
		reverse_n = 1'b1;
		expect_dark = 1'b0;
		expect_run = 1'b0;
		error_count = 0;
		check_count = 0;
		timed_out = 1'b0;

		apply_reset();
		check_idle_dark();
		check_lamp_test();
		check_forward_walk();
		check_reset_mid_run();
		check_reverse_walk();

		$display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timed_out);
		if (error_count == 0 && !timed_out) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
logic/cube_pkg.sv
logic/cube_sequencer.sv
logic/dwell_timer.sv
logic/frame_stepper.sv
logic/frame_pattern.sv
logic/cube_driver.sv
logic/led_cube_top.sv
verif/tb_led_cube.sv

/* Bender.yml */
package:
  name: led_cube

sources:
  # Package first, then the leaf modules and the top level
  - logic/cube_pkg.sv
  - logic/cube_sequencer.sv
  - logic/dwell_timer.sv
  - logic/frame_stepper.sv
  - logic/frame_pattern.sv
  - logic/cube_driver.sv
  - logic/led_cube_top.sv
  - target: simulation
    files:
      - verif/tb_led_cube.sv
